// ==== Bender.yml ====
package:
  name: dbg_ahb_biu

sources:
  - verilog/dbg_ahb_pkg.sv
  - verilog/dbg_req_if.sv
  - verilog/dbg_req_capture.sv
  - verilog/dbg_toggle_sync.sv
  - verilog/dbg_ahb_fsm.sv
  - verilog/dbg_ahb_timeout.sv
  - verilog/dbg_rdata_align.sv
  - verilog/dbg_ahb_biu.sv
  - target: simulation
    files:
      - dv/ahb_mem_slave.sv
      - dv/dbg_ahb_biu_tb.sv

// ==== dbg_ahb_biu.f ====
verilog/dbg_ahb_pkg.sv
verilog/dbg_req_if.sv
verilog/dbg_req_capture.sv
verilog/dbg_toggle_sync.sv
verilog/dbg_ahb_fsm.sv
verilog/dbg_ahb_timeout.sv
verilog/dbg_rdata_align.sv
verilog/dbg_ahb_biu.sv
dv/ahb_mem_slave.sv
dv/dbg_ahb_biu_tb.sv

// ==== dv/ahb_mem_slave.sv ====
// Behavioral slave, one transfer at a time; 64 words mirrored over each 256-byte block
`timescale 1ns/1ps

module ahb_mem_slave (
  input  logic        HCLK,
  input  logic        ahb_rstn,
  input  logic        HSEL,
  input  logic [31:0] HADDR,
  input  logic        HWRITE,
  input  logic [2:0]  HSIZE,
  input  logic [1:0]  HTRANS,
  input  logic [31:0] HWDATA,
  input  logic [1:0]  wait_sel,
  output logic [31:0] HRDATA,
  output logic        HREADY,
  output logic        HRESP
);
  import dbg_ahb_pkg::*;

  logic [31:0] mem [0:63];
  logic [31:0] merged;
  logic [31:0] addr_q;
  logic [2:0]  size_q;
  logic [1:0]  wait_left;
  logic [3:0]  lane_en;
  logic        busy;
  logic        write_q;
  logic        err_q;
  logic        stall_q;

  // Fill pattern from the full word index
  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[i] = 32'h6b000000 ^ (i * 32'h00010305);
    end
  end

  // Stall region holds HREADY low until the master moves HADDR away
  assign HREADY = !(busy && (stall_q ? (HADDR >= 32'h200) : (wait_left != 2'd0)));
  assign HRESP  = busy && err_q;
  assign HRDATA = mem[addr_q[7:2]];

  // Byte lanes of the captured transfer, little-endian
  assign lane_en = (size_q == hsize_byte) ? (4'b0001 << addr_q[1:0]) :
                   (size_q == hsize_half) ? (addr_q[1] ? 4'b1100 : 4'b0011) : 4'b1111;

  //////////////////////////////////////////////////////////////////////
  // Address and data phase tracking
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      busy      <= 1'b0;
      addr_q    <= '0;
      size_q    <= hsize_word;
      write_q   <= 1'b0;
      err_q     <= 1'b0;
      stall_q   <= 1'b0;
      wait_left <= 2'd0;
    end else begin
      if (busy && HREADY) begin
        busy <= 1'b0;
      end else if (busy && !stall_q && (wait_left != 2'd0)) begin
        wait_left <= wait_left - 1'b1;
      end
      // New transfer accepted in its address phase
      if (HSEL && (HTRANS == htrans_nonseq) && HREADY) begin
        busy      <= 1'b1;
        addr_q    <= HADDR;
        size_q    <= HSIZE;
        write_q   <= HWRITE;
        err_q     <= (HADDR >= 32'h100) && (HADDR < 32'h200);
        stall_q   <= HADDR >= 32'h200;
        // Error response is one wait cycle, then the second HRESP cycle
        wait_left <= (HADDR >= 32'h100) ? 2'd1 : wait_sel;
      end
    end
  end

  // Write lands when the data phase completes
  always @(posedge HCLK) begin
    if (busy && HREADY && write_q && !err_q && !stall_q) begin
      merged = mem[addr_q[7:2]];
      for (int i = 0; i < 4; i++) begin
        if (lane_en[i]) begin
          merged[8*i +: 8] = HWDATA[8*i +: 8];
        end
      end
      mem[addr_q[7:2]] <= merged;
    end
  end

endmodule

// ==== dv/dbg_ahb_biu_tb.sv ====
// Reads only target words written earlier in the run; LFSR seed is fixed, so runs repeat exactly
`timescale 1ns/1ps

module dbg_ahb_biu_tb;
  import dbg_ahb_pkg::*;

  localparam int n_word   = 8;
  localparam int n_access = 2 * n_word + 13 + 7 + 3 + 2;
  // Worst case per access: start sync, address, timed-out data phase, done sync, margin
  localparam int access_ns     = (wait_limit + 10) * 40 + 10 * 60;
  localparam int access_cycles = access_ns / 60;

  logic        HCLK = 1'b0;
  logic        dbg_clk = 1'b0;
  logic        ahb_rstn;
  logic [31:0] dbg_di;
  logic [31:0] dbg_do;
  logic [31:0] dbg_addr;
  logic        dbg_strb;
  logic        dbg_rw;
  logic        dbg_rdy;
  logic        dbg_err;
  logic [3:0]  dbg_word_size;
  logic        HSEL;
  logic [31:0] HADDR;
  logic [31:0] HWDATA;
  logic        HWRITE;
  logic [2:0]  HSIZE;
  logic [2:0]  HBURST;
  logic [3:0]  HPROT;
  logic [1:0]  HTRANS;
  logic        HMASTLOCK;
  logic [31:0] HRDATA;
  logic        HREADY;
  logic        HRESP;
  logic [1:0]  wait_sel;

  // Reference memory, same word indexing as the slave
  logic [31:0] ref_mem [0:63];
  logic [31:0] lfsr = 32'h57d1680e;
  logic [2:0]  exp_hsize;
  logic [31:0] exp_haddr;
  logic        exp_hwrite;
  string       test_name = "reset";
  int          errors = 0;
  int          accepted = 0;
  int          nonseq_cnt = 0;

  always #20 HCLK = ~HCLK;
  always #30 dbg_clk = ~dbg_clk;

  dbg_ahb_biu dbg_ahb_biu_inst (.*);
  ahb_mem_slave mem_slave (.*);

  //////////////////////////////////////////////////////////////////////
  // Random source and checks
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  // Address phase attributes, sampled away from the HCLK edge
  always @(negedge HCLK) begin
    if (ahb_rstn && (HTRANS == htrans_nonseq)) begin
      nonseq_cnt++;
      expect_eq("HSEL", 32'd1, {31'd0, HSEL});
      expect_eq("HBURST", {29'd0, hburst_single}, {29'd0, HBURST});
      expect_eq("HSIZE", {29'd0, exp_hsize}, {29'd0, HSIZE});
      expect_eq("HADDR", exp_haddr, HADDR);
      expect_eq("HWRITE", {31'd0, exp_hwrite}, {31'd0, HWRITE});
      // Data, privileged, non-bufferable, non-cacheable
      expect_eq("HPROT", 32'h3, {28'd0, HPROT});
      expect_eq("HMASTLOCK", 32'd0, {31'd0, HMASTLOCK});
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Debug side accesses
  //////////////////////////////////////////////////////////////////////

  // One request; extra_strb pulses dbg_strb again while the DUT is busy
  task automatic dbg_access(input logic rw, input logic [31:0] addr, input logic [3:0] size,
                            input logic [31:0] di, input logic extra_strb,
                            output logic [31:0] rdata, output logic rerr);
    int          cycles;
    logic [31:0] wait_bits;
    @(negedge dbg_clk);
    expect_eq("dbg_rdy before strobe", 32'd1, {31'd0, dbg_rdy});
    wait_bits = rand_bits(2);
    wait_sel  = wait_bits[1:0];
    case (size)
      wsize_byte: exp_hsize = hsize_byte;
      wsize_half: exp_hsize = hsize_half;
      default:    exp_hsize = hsize_word;
    endcase
    exp_haddr     = addr;
    exp_hwrite    = ~rw;
    dbg_addr      = addr;
    dbg_rw        = rw;
    dbg_di        = di;
    dbg_word_size = size;
    dbg_strb      = 1'b1;
    accepted++;
    @(negedge dbg_clk);
    expect_eq("dbg_rdy after accept", 32'd0, {31'd0, dbg_rdy});
    dbg_strb = extra_strb;
    if (extra_strb) begin
      @(negedge dbg_clk);
      dbg_strb = 1'b0;
    end
    cycles = 0;
    while (!dbg_rdy && (cycles < access_cycles)) begin
      @(negedge dbg_clk);
      cycles++;
    end
    assert (dbg_rdy) else begin
      errors++;
      $display("%s: dbg_rdy did not return within %0d dbg_clk cycles", test_name, cycles);
    end
    expect_eq("nonseq cycles", accepted, nonseq_cnt);
    rdata = dbg_do;
    rerr  = dbg_err;
  endtask

  // Narrow data goes in the top bits of dbg_di
  task automatic write_mem(input logic [31:0] addr, input logic [3:0] size,
                           input logic [31:0] v, input logic extra_strb);
    logic [31:0] rdata;
    logic [31:0] word;
    logic        rerr;
    dbg_access(1'b0, addr, size, v << (8 * (4 - size)), extra_strb, rdata, rerr);
    expect_eq("dbg_err", 32'd0, {31'd0, rerr});
    word = ref_mem[addr[7:2]];
    for (int k = 0; k < size; k++) begin
      word[8 * (addr[1:0] + k) +: 8] = v[8 * k +: 8];
    end
    ref_mem[addr[7:2]] = word;
  endtask

  // Expected value is the addressed lanes, zero-extended
  task automatic read_check(input logic [31:0] addr, input logic [3:0] size);
    logic [31:0] rdata;
    logic [31:0] word;
    logic [31:0] exp;
    logic        rerr;
    word = ref_mem[addr[7:2]];
    exp  = '0;
    for (int k = 0; k < size; k++) begin
      exp[8 * k +: 8] = word[8 * (addr[1:0] + k) +: 8];
    end
    dbg_access(1'b1, addr, size, 32'h0, 1'b0, rdata, rerr);
    expect_eq("dbg_do", exp, rdata);
    expect_eq("dbg_err", 32'd0, {31'd0, rerr});
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] word_addr [0:n_word-1];
    logic [31:0] base;
    logic [31:0] rdata;
    logic        rerr;
    ahb_rstn      = 1'b0;
    dbg_di        = '0;
    dbg_addr      = '0;
    dbg_strb      = 1'b0;
    dbg_rw        = 1'b1;
    dbg_word_size = wsize_word;
    wait_sel      = 2'd0;
    exp_hsize     = hsize_word;
    exp_haddr     = '0;
    exp_hwrite    = 1'b0;
    repeat (10) @(posedge HCLK);
    // Release between the edges of both clocks
    @(negedge HCLK);
    ahb_rstn = 1'b1;
    @(negedge dbg_clk);
    expect_eq("dbg_rdy", 32'd1, {31'd0, dbg_rdy});
    expect_eq("HTRANS", {30'd0, htrans_idle}, {30'd0, HTRANS});
    expect_eq("dbg_err", 32'd0, {31'd0, dbg_err});

    // First write also strobes while busy
    test_name = "word_access";
    for (int i = 0; i < n_word; i++) begin
      word_addr[i] = rand_bits(6) << 2;
      write_mem(word_addr[i], wsize_word, rand_bits(32), i == 0);
    end
    for (int i = 0; i < n_word; i++) begin
      read_check(word_addr[i], wsize_word);
    end

    test_name = "byte_access";
    base = rand_bits(6) << 2;
    write_mem(base, wsize_word, rand_bits(32), 1'b0);
    for (int o = 0; o < 4; o++) begin
      write_mem(base + o, wsize_byte, rand_bits(8), 1'b0);
      read_check(base, wsize_word);
      read_check(base + o, wsize_byte);
    end

    test_name = "half_access";
    base = rand_bits(6) << 2;
    write_mem(base, wsize_word, rand_bits(32), 1'b0);
    for (int o = 0; o < 4; o += 2) begin
      write_mem(base + o, wsize_half, rand_bits(16), 1'b0);
      read_check(base, wsize_word);
      read_check(base + o, wsize_half);
    end

    // Error region never updates memory, the write aliases onto base
    test_name = "error_resp";
    dbg_access(1'b1, 32'h100 + (rand_bits(6) << 2), wsize_word, 32'h0, 1'b0, rdata, rerr);
    expect_eq("dbg_err", 32'd1, {31'd0, rerr});
    dbg_access(1'b0, 32'h100 + base, wsize_word, rand_bits(32), 1'b0, rdata, rerr);
    expect_eq("dbg_err", 32'd1, {31'd0, rerr});
    read_check(base, wsize_word);

    test_name = "stall";
    dbg_access(1'b1, 32'h200, wsize_word, 32'h0, 1'b0, rdata, rerr);
    expect_eq("dbg_err", 32'd1, {31'd0, rerr});
    // Slave still holds HREADY low, master stays off the bus
    repeat (20) begin
      @(negedge HCLK);
      expect_eq("HTRANS", {30'd0, htrans_idle}, {30'd0, HTRANS});
    end
    read_check(word_addr[0], wsize_word);

    test_name = "summary";
    expect_eq("nonseq cycles", accepted, nonseq_cnt);
    $display("Accesses: %0d, nonseq cycles: %0d, errors: %0d", accepted, nonseq_cnt, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Bound from the access count and worst case access time
  initial begin
    #(400 + (n_access + 2) * access_ns);
    $display("Watchdog expired before the test sequence finished");
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== verilog/dbg_ahb_biu.sv ====
// No reset synchronizers; ahb_rstn must be released cleanly relative to both dbg_clk and HCLK
`timescale 1ns/1ps

module dbg_ahb_biu (
  // Debug transport side
  input  logic                           dbg_clk,
  input  logic                           HCLK,
  input  logic                           ahb_rstn,
  input  logic [dbg_ahb_pkg::data_w-1:0] dbg_di,
  output logic [dbg_ahb_pkg::data_w-1:0] dbg_do,
  input  logic [dbg_ahb_pkg::addr_w-1:0] dbg_addr,
  input  logic                           dbg_strb,
  input  logic                           dbg_rw,
  output logic                           dbg_rdy,
  output logic                           dbg_err,
  input  logic [3:0]                     dbg_word_size,
  // AHB-Lite master
  output logic                           HSEL,
  output logic [dbg_ahb_pkg::addr_w-1:0] HADDR,
  output logic [dbg_ahb_pkg::data_w-1:0] HWDATA,
  output logic                           HWRITE,
  output logic [2:0]                     HSIZE,
  output logic [2:0]                     HBURST,
  output logic [3:0]                     HPROT,
  output logic [1:0]                     HTRANS,
  output logic                           HMASTLOCK,
  input  logic [dbg_ahb_pkg::data_w-1:0] HRDATA,
  input  logic                           HREADY,
  input  logic                           HRESP
);
  import dbg_ahb_pkg::*;

  fsm_state_e state;
  logic       start_pulse;
  logic       done_pulse;
  logic       done_tgl;
  logic       ack;
  logic       expired;

  dbg_req_if req_bus ();

  //////////////////////////////////////////////////////////////////////
  // Debug clock domain
  //////////////////////////////////////////////////////////////////////

  dbg_req_capture req_capture (
    .dbg_clk(dbg_clk), .ahb_rstn(ahb_rstn), .dbg_di(dbg_di), .dbg_addr(dbg_addr),
    .dbg_strb(dbg_strb), .dbg_rw(dbg_rw), .dbg_word_size(dbg_word_size),
    .done_pulse(done_pulse), .dbg_rdy(dbg_rdy), .req(req_bus.src)
  );

  // Completion back from HCLK
  dbg_toggle_sync done_sync (
    .clk(dbg_clk), .ahb_rstn(ahb_rstn), .tgl_in(done_tgl), .pulse(done_pulse)
  );

  //////////////////////////////////////////////////////////////////////
  // HCLK domain
  //////////////////////////////////////////////////////////////////////

  dbg_toggle_sync start_sync (
    .clk(HCLK), .ahb_rstn(ahb_rstn), .tgl_in(req_bus.start_tgl), .pulse(start_pulse)
  );

  dbg_ahb_fsm ahb_fsm (
    .HCLK(HCLK), .ahb_rstn(ahb_rstn), .start_pulse(start_pulse), .HREADY(HREADY),
    .expired(expired), .HTRANS(HTRANS), .state(state), .ack(ack), .done_tgl(done_tgl)
  );

  dbg_ahb_timeout ahb_timeout (
    .HCLK(HCLK), .ahb_rstn(ahb_rstn), .state(state), .HREADY(HREADY), .expired(expired)
  );

  dbg_rdata_align rdata_align (
    .HCLK(HCLK), .ahb_rstn(ahb_rstn), .ack(ack), .expired(expired), .HRDATA(HRDATA),
    .HRESP(HRESP), .dbg_do(dbg_do), .dbg_err(dbg_err), .req(req_bus.dst)
  );

  // Address and data phase fields straight from the latched request
  assign HADDR     = req_bus.addr;
  assign HWDATA    = req_bus.wdata;
  assign HWRITE    = req_bus.write;
  assign HSIZE     = req_bus.hsize;
  // Fixed attributes
  assign HSEL      = 1'b1;
  assign HBURST    = hburst_single;
  assign HPROT     = hprot_dbg;
  assign HMASTLOCK = 1'b0;

endmodule

// ==== verilog/dbg_ahb_fsm.sv ====
// Single NONSEQ transfers only; address phase assumes HREADY high, as after a completed transfer
`timescale 1ns/1ps

module dbg_ahb_fsm (
  input  logic                    HCLK,
  input  logic                    ahb_rstn,
  input  logic                    start_pulse,
  input  logic                    HREADY,
  input  logic                    expired,
  output logic [1:0]              HTRANS,
  output dbg_ahb_pkg::fsm_state_e state,
  output logic                    ack,
  output logic                    done_tgl
);
  import dbg_ahb_pkg::*;

  logic start_hold;
  logic start_req;

  // Fresh or held start request
  assign start_req = start_pulse || start_hold;

  // Keep a start that lands while a transfer is still running
  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      start_hold <= 1'b0;
    end else begin
      start_hold <= start_req && (state != state_idle);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Transfer sequencing
  //////////////////////////////////////////////////////////////////////

  // Data phase ends on HREADY, or on the wait-state timeout
  assign ack = (state == state_data) && (HREADY || expired);

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      state  <= state_idle;
      HTRANS <= htrans_idle;
    end else begin
      case (state)
        state_idle: begin
          if (start_req) begin
            // NONSEQ is driven for the address phase only
            state  <= state_addr;
            HTRANS <= htrans_nonseq;
          end
        end
        state_addr: begin
          state  <= state_data;
          HTRANS <= htrans_idle;
        end
        state_data: begin
          if (ack) begin
            state <= state_idle;
          end
        end
        default: begin
          state  <= state_idle;
          HTRANS <= htrans_idle;
        end
      endcase
    end
  end

  // One toggle per finished transfer, back to the debug clock
  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      done_tgl <= 1'b0;
    end else if (ack) begin
      done_tgl <= ~done_tgl;
    end
  end

endmodule

// ==== verilog/dbg_ahb_pkg.sv ====
// Constants for a 32-bit little-endian AHB-Lite debug master; no 64-bit path and no bursts
package dbg_ahb_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////

  // Data path is one word on both the debug and the AHB side
  localparam int unsigned data_w = 32;
  localparam int unsigned addr_w = 32;

  //////////////////////////////////////////////////////////////////////
  // AHB-Lite encodings
  //////////////////////////////////////////////////////////////////////

  localparam logic [1:0] htrans_idle   = 2'b00;
  localparam logic [1:0] htrans_nonseq = 2'b10;

  localparam logic [2:0] hsize_byte = 3'b000;
  localparam logic [2:0] hsize_half = 3'b001;
  localparam logic [2:0] hsize_word = 3'b010;

  localparam logic [2:0] hburst_single = 3'b000;

  // Data access, privileged, non-bufferable, non-cacheable
  localparam logic [3:0] hprot_dbg = 4'b0011;

  // Debug word size codes, in bytes
  localparam logic [3:0] wsize_byte = 4'd1;
  localparam logic [3:0] wsize_half = 4'd2;
  localparam logic [3:0] wsize_word = 4'd4;

  // HREADY-low data phase cycles before the transfer is abandoned
  localparam int unsigned wait_limit = 16;

  // AHB transfer FSM states
  typedef enum logic [1:0] {
    state_idle = 2'b00,
    state_addr = 2'b01,
    state_data = 2'b10
  } fsm_state_e;

endpackage

// ==== verilog/dbg_ahb_timeout.sv ====
// A timed-out transfer is abandoned on the master side; the slave is not told
`timescale 1ns/1ps

module dbg_ahb_timeout (
  input  logic                    HCLK,
  input  logic                    ahb_rstn,
  input  dbg_ahb_pkg::fsm_state_e state,
  input  logic                    HREADY,
  output logic                    expired
);
  import dbg_ahb_pkg::*;

  // Wide enough to hold wait_limit itself
  logic [$clog2(wait_limit + 1)-1:0] wait_cnt;

  // Consecutive stalled data phase cycles
  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      wait_cnt <= '0;
    end else if ((state == state_data) && !HREADY) begin
      // Saturate at the limit
      if (!expired) begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end else begin
      wait_cnt <= '0;
    end
  end

  // FSM leaves the data phase on this, which clears the count
  assign expired = (wait_cnt == wait_limit);

endmodule

// ==== verilog/dbg_rdata_align.sv ====
// Little-endian lanes only; dbg_do and dbg_err are held until the next ack
`timescale 1ns/1ps

module dbg_rdata_align (
  input  logic                           HCLK,
  input  logic                           ahb_rstn,
  input  logic                           ack,
  input  logic                           expired,
  input  logic [dbg_ahb_pkg::data_w-1:0] HRDATA,
  input  logic                           HRESP,
  output logic [dbg_ahb_pkg::data_w-1:0] dbg_do,
  output logic                           dbg_err,
  dbg_req_if.dst                         req
);
  import dbg_ahb_pkg::*;

  // Error flag, timeout counts as a bus error
  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      dbg_err <= 1'b0;
    end else if (ack) begin
      dbg_err <= HRESP || expired;
    end
  end

  // Read result, narrow reads zero-extended from their lane
  always_ff @(posedge HCLK) begin
    if (ack) begin
      case (req.hsize)
        hsize_byte: begin
          case (req.addr[1:0])
            2'b00:   dbg_do <= {24'h0, HRDATA[7 -: 8]};
            2'b01:   dbg_do <= {24'h0, HRDATA[15 -: 8]};
            2'b10:   dbg_do <= {24'h0, HRDATA[23 -: 8]};
            default: dbg_do <= {24'h0, HRDATA[31 -: 8]};
          endcase
        end
        hsize_half: begin
          // addr[0] ignored, halfwords are aligned
          dbg_do <= req.addr[1] ? {16'h0, HRDATA[31 -: 16]} : {16'h0, HRDATA[15 -: 16]};
        end
        default: begin
          dbg_do <= HRDATA;
        end
      endcase
    end
  end

endmodule

// ==== verilog/dbg_req_capture.sv ====
// Accepts one request at a time; a strobe while dbg_rdy is low is dropped, not queued
`timescale 1ns/1ps

module dbg_req_capture (
  input  logic                         dbg_clk,
  input  logic                         ahb_rstn,
  input  logic [dbg_ahb_pkg::data_w-1:0] dbg_di,
  input  logic [dbg_ahb_pkg::addr_w-1:0] dbg_addr,
  input  logic                         dbg_strb,
  input  logic                         dbg_rw,
  input  logic [3:0]                   dbg_word_size,
  input  logic                         done_pulse,
  output logic                         dbg_rdy,
  dbg_req_if.src                       req
);
  import dbg_ahb_pkg::*;

  logic accept;

  // Request taken on strobe while idle
  assign accept = dbg_strb && dbg_rdy;

  //////////////////////////////////////////////////////////////////////
  // Request payload
  //////////////////////////////////////////////////////////////////////

  // Held from acceptance until the next acceptance
  always_ff @(posedge dbg_clk) begin
    if (accept) begin
      req.addr  <= dbg_addr;
      // dbg_rw high means read
      req.write <= ~dbg_rw;

      // Size code and lane replication; the debug side puts
      // narrow data in the top bits of dbg_di
      case (dbg_word_size)
        wsize_byte: begin
          req.hsize <= hsize_byte;
          req.wdata <= {4{dbg_di[31 -: 8]}};
        end
        wsize_half: begin
          req.hsize <= hsize_half;
          req.wdata <= {2{dbg_di[31 -: 16]}};
        end
        default: begin
          // Word, and anything unknown treated as a word
          req.hsize <= hsize_word;
          req.wdata <= dbg_di;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////////////////////////

  // Start toggle crosses to HCLK, ready falls until completion
  always_ff @(posedge dbg_clk or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      req.start_tgl <= 1'b0;
      dbg_rdy       <= 1'b1;
    end else begin
      if (accept) begin
        req.start_tgl <= ~req.start_tgl;
        dbg_rdy       <= 1'b0;
      end else if (done_pulse) begin
        dbg_rdy <= 1'b1;
      end
    end
  end

endmodule

// ==== verilog/dbg_req_if.sv ====
// Request fields are quasi-static; the AHB side may sample them only after start_tgl syncs
`timescale 1ns/1ps

interface dbg_req_if;
  import dbg_ahb_pkg::*;

  // Latched request, written in the debug clock domain
  logic [addr_w-1:0] addr;
  // Write data, already replicated over the active lanes
  logic [data_w-1:0] wdata;
  logic              write;
  logic [2:0]        hsize;
  // Flips once per accepted request
  logic              start_tgl;

  // Debug-side request latch
  modport src (
    output addr, wdata, write, hsize, start_tgl
  );

  // AHB-side consumers
  modport dst (
    input addr, wdata, write, hsize, start_tgl
  );

endinterface

// ==== verilog/dbg_toggle_sync.sv ====
// Toggles on tgl_in must be spaced by more than three clk cycles or pulses merge
`timescale 1ns/1ps

module dbg_toggle_sync (
  input  logic clk,
  input  logic ahb_rstn,
  input  logic tgl_in,
  output logic pulse
);

  // Two metastability flops, then one delayed copy
  logic sync_q1;
  logic sync_q2;
  logic sync_q3;

  always_ff @(posedge clk or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
      sync_q3 <= 1'b0;
    end else begin
      sync_q1 <= tgl_in;
      sync_q2 <= sync_q1;
      sync_q3 <= sync_q2;
    end
  end

  // Any change of the synchronized level is one event
  assign pulse = sync_q2 ^ sync_q3;

endmodule
